/* Bender.yml */
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/way_store.sv
  - source/req_decode.sv
  - source/cache_ctrl.sv
  - source/resp_mux.sv
  - source/dcache_top.sv
  - target: test
    files:
      - test/dcache_props.sv
      - test/dcache_tb.sv

/* project.f */
source/dcache_pkg.sv
source/way_store.sv
source/req_decode.sv
source/cache_ctrl.sv
source/resp_mux.sv
source/dcache_top.sv
test/dcache_props.sv
test/dcache_tb.sv

/* source/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        dec_valid_i,
    input  dcache_pkg::decoded_req_t    dec_i,
    input  dcache_pkg::way_rd_t         way0_rd_i,
    input  dcache_pkg::way_rd_t         way1_rd_i,
    input  logic                        mem_ret_valid_i,
    input  dcache_pkg::line_t           mem_ret_data_i,
    input  logic                        mem_wr_done_i,
    input  logic                        unc_done_i,
    output logic                        busy_o,
    output dcache_pkg::way_wr_t         way0_wr_o,
    output dcache_pkg::way_wr_t         way1_wr_o,
    output logic                        mem_rd_req_o,
    output logic [31:0]                 mem_rd_addr_o,
    output logic                        mem_wr_req_o,
    output logic [31:0]                 mem_wr_addr_o,
    output dcache_pkg::line_t           mem_wr_data_o,
    output logic                        unc_req_valid_o,
    output dcache_pkg::unc_req_t        unc_req_o,
    output logic                        rsp_fire_o,
    output dcache_pkg::rsp_sel_e        rsp_sel_o,
    output logic                        rsp_miss_o,
    output dcache_pkg::line_t           refill_line_o
);

    dcache_pkg::ctrl_state_e state_q, state_d, cur_state;

    logic [dcache_pkg::NUM_SETS-1:0]      lru_q;   // way to evict next
    logic [dcache_pkg::NUM_SETS-1:0][1:0] dirty_q;

    logic hit0, hit1, hit, is_store;
    logic in_lookup, cached_lookup, lookup_hit, refill_done;
    logic victim, victim_dirty;
    logic wr_en, wr_way;
    dcache_pkg::way_rd_t victim_rd;
    dcache_pkg::line_t   line_mask, wdata_line, hit_line;
    dcache_pkg::way_wr_t wr;

    // registered request lands exactly in the lookup cycle
    assign cur_state     = dec_valid_i ? dcache_pkg::ST_LOOKUP : state_q;
    assign busy_o        = (cur_state != dcache_pkg::ST_IDLE);
    assign in_lookup     = (cur_state == dcache_pkg::ST_LOOKUP);
    assign cached_lookup = in_lookup && !dec_i.uncached;
    assign is_store      = (dec_i.op == dcache_pkg::OP_WRITE);

    assign hit0        = way0_rd_i.valid && (way0_rd_i.tag == dec_i.tag);
    assign hit1        = way1_rd_i.valid && (way1_rd_i.tag == dec_i.tag);
    assign hit         = hit0 || hit1;
    assign lookup_hit  = cached_lookup && hit;
    assign refill_done = (cur_state == dcache_pkg::ST_REFILL) && mem_ret_valid_i;

    assign victim       = lru_q[dec_i.index];
    assign victim_rd    = victim ? way1_rd_i : way0_rd_i;
    assign victim_dirty = victim_rd.valid && dirty_q[dec_i.index][victim];

    // store bytes at their word position, nothing for loads
    assign wdata_line = {dcache_pkg::LINE_WORDS{dec_i.wdata}};
    assign line_mask  = is_store ? (dcache_pkg::line_t'(dec_i.bmask) << {dec_i.word, 5'b0}) : '0;
    assign hit_line   = hit1 ? way1_rd_i.line : way0_rd_i.line;

    assign refill_line_o = (mem_ret_data_i & ~line_mask) | (wdata_line & line_mask);

    always_comb begin
        wr       = '0;
        wr.index = dec_i.index;
        wr.tag   = dec_i.tag;
        wr.valid = 1'b1;
        if (refill_done) begin
            wr.tag_we  = 1'b1;
            wr.word_we = '1;
            wr.data    = refill_line_o;
        end else begin
            wr.word_we[dec_i.word] = 1'b1;   // store hit touches one bank
            wr.data = (hit_line & ~line_mask) | (wdata_line & line_mask);
        end
    end

    assign wr_en  = refill_done || (lookup_hit && is_store);
    assign wr_way = refill_done ? victim : hit1;

    always_comb begin
        way0_wr_o         = wr;
        way1_wr_o         = wr;
        way0_wr_o.tag_we  = wr.tag_we && wr_en && !wr_way;
        way1_wr_o.tag_we  = wr.tag_we && wr_en && wr_way;
        way0_wr_o.word_we = wr.word_we & {dcache_pkg::LINE_WORDS{wr_en && !wr_way}};
        way1_wr_o.word_we = wr.word_we & {dcache_pkg::LINE_WORDS{wr_en && wr_way}};
    end

    // dirty victim goes out whole before the refill
    assign mem_wr_req_o  = cached_lookup && !hit && victim_dirty;
    assign mem_wr_addr_o = {victim_rd.tag, dec_i.index, 5'b0};
    assign mem_wr_data_o = victim_rd.line;
    assign mem_rd_req_o  = (cached_lookup && !hit && !victim_dirty) ||
                           ((cur_state == dcache_pkg::ST_WRITEBACK) && mem_wr_done_i);
    assign mem_rd_addr_o = {dec_i.tag, dec_i.index, 5'b0};

    assign unc_req_valid_o = in_lookup && dec_i.uncached;
    assign unc_req_o = '{op: dec_i.op, addr: dec_i.addr, wdata: dec_i.wdata, wstrb: dec_i.wstrb};

    always_comb begin
        rsp_fire_o = 1'b0;
        rsp_sel_o  = hit1 ? dcache_pkg::SEL_WAY1 : dcache_pkg::SEL_WAY0;
        rsp_miss_o = 1'b0;
        case (cur_state)
            dcache_pkg::ST_LOOKUP: rsp_fire_o = lookup_hit;
            dcache_pkg::ST_REFILL: begin
                rsp_fire_o = mem_ret_valid_i;
                rsp_sel_o  = dcache_pkg::SEL_REFILL;
                rsp_miss_o = 1'b1;
            end
            dcache_pkg::ST_UNCACHED: begin
                rsp_fire_o = unc_done_i;
                rsp_sel_o  = dcache_pkg::SEL_UNC;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = cur_state;
        case (cur_state)
            dcache_pkg::ST_LOOKUP: begin
                if (dec_i.uncached) begin
                    state_d = dcache_pkg::ST_UNCACHED;
                end else if (hit) begin
                    state_d = dcache_pkg::ST_IDLE;   // answered this cycle
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::ST_WRITEBACK;
                end else begin
                    state_d = dcache_pkg::ST_REFILL;
                end
            end
            dcache_pkg::ST_WRITEBACK: if (mem_wr_done_i) state_d = dcache_pkg::ST_REFILL;
            dcache_pkg::ST_REFILL:    if (mem_ret_valid_i) state_d = dcache_pkg::ST_RESPOND;
            dcache_pkg::ST_UNCACHED:  if (unc_done_i) state_d = dcache_pkg::ST_RESPOND;
            default: state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= dcache_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else if (lookup_hit) begin
            lru_q[dec_i.index] <= hit0;   // the other way is now older
            if (is_store) begin
                dirty_q[dec_i.index][hit1] <= 1'b1;
            end
        end else if (refill_done) begin
            lru_q[dec_i.index]           <= !victim;
            dirty_q[dec_i.index][victim] <= is_store;
        end
    end

endmodule

/* source/dcache_pkg.sv */
package dcache_pkg;

    localparam int INDEX_W    = 7;
    localparam int WORD_W     = 3;
    localparam int TAG_W      = 20;
    localparam int LINE_WORDS = 8;
    localparam int NUM_SETS   = 128;

    typedef logic [LINE_WORDS*32-1:0] line_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_UNCACHED,
        ST_RESPOND
    } ctrl_state_e;

    // where the returned word comes from
    typedef enum logic [1:0] {
        SEL_WAY0,
        SEL_WAY1,
        SEL_REFILL,
        SEL_UNC
    } rsp_sel_e;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        uncached;
    } cache_req_t;

    typedef struct packed {
        mem_op_e             op;
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [WORD_W-1:0]   word;
        logic [31:0]         wdata;
        logic [31:0]         bmask;    // wstrb spread to bits
        logic [3:0]          wstrb;
        logic                uncached;
        logic [31:0]         addr;
    } decoded_req_t;

    typedef struct packed {
        logic                  tag_we;
        logic [LINE_WORDS-1:0] word_we;
        logic [INDEX_W-1:0]    index;
        logic [TAG_W-1:0]      tag;
        logic                  valid;
        line_t                 data;
    } way_wr_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        line_t            line;
    } way_rd_t;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } unc_req_t;

endpackage

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid_i,
    input  dcache_pkg::cache_req_t  req_i,
    input  logic                    mem_ret_valid_i,
    input  dcache_pkg::line_t       mem_ret_data_i,
    input  logic                    mem_wr_done_i,
    input  logic                    unc_done_i,
    input  logic [31:0]             unc_rdata_i,
    output logic                    busy_o,
    output logic                    rsp_valid_o,
    output logic [31:0]             rsp_rdata_o,
    output logic                    rsp_miss_o,
    output logic                    mem_rd_req_o,
    output logic [31:0]             mem_rd_addr_o,
    output logic                    mem_wr_req_o,
    output logic [31:0]             mem_wr_addr_o,
    output dcache_pkg::line_t       mem_wr_data_o,
    output logic                    unc_req_valid_o,
    output dcache_pkg::unc_req_t    unc_req_o
);

    logic                               dec_valid;
    dcache_pkg::decoded_req_t           dec;
    logic [dcache_pkg::INDEX_W-1:0]     rd_index;
    dcache_pkg::way_wr_t                way0_wr;
    dcache_pkg::way_wr_t                way1_wr;
    dcache_pkg::way_rd_t                way0_rd;
    dcache_pkg::way_rd_t                way1_rd;
    logic                               rsp_fire;
    dcache_pkg::rsp_sel_e               rsp_sel;
    logic                               rsp_miss;
    dcache_pkg::line_t                  refill_line;

    req_decode decode0 (
        .clk         (clk),
        .reset       (reset),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .dec_valid_o (dec_valid),
        .dec_o       (dec),
        .rd_index_o  (rd_index)
    );

    cache_ctrl ctrl0 (
        .clk             (clk),
        .reset           (reset),
        .dec_valid_i     (dec_valid),
        .dec_i           (dec),
        .way0_rd_i       (way0_rd),
        .way1_rd_i       (way1_rd),
        .mem_ret_valid_i (mem_ret_valid_i),
        .mem_ret_data_i  (mem_ret_data_i),
        .mem_wr_done_i   (mem_wr_done_i),
        .unc_done_i      (unc_done_i),
        .busy_o          (busy_o),
        .way0_wr_o       (way0_wr),
        .way1_wr_o       (way1_wr),
        .mem_rd_req_o    (mem_rd_req_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_wr_req_o    (mem_wr_req_o),
        .mem_wr_addr_o   (mem_wr_addr_o),
        .mem_wr_data_o   (mem_wr_data_o),
        .unc_req_valid_o (unc_req_valid_o),
        .unc_req_o       (unc_req_o),
        .rsp_fire_o      (rsp_fire),
        .rsp_sel_o       (rsp_sel),
        .rsp_miss_o      (rsp_miss),
        .refill_line_o   (refill_line)
    );

    way_store way0 (.clk(clk), .reset(reset), .rd_index_i(rd_index), .wr_i(way0_wr), .rd_o(way0_rd));
    way_store way1 (.clk(clk), .reset(reset), .rd_index_i(rd_index), .wr_i(way1_wr), .rd_o(way1_rd));

    resp_mux resp0 (
        .clk           (clk),
        .reset         (reset),
        .rsp_fire_i    (rsp_fire),
        .rsp_sel_i     (rsp_sel),
        .rsp_miss_i    (rsp_miss),
        .word_i        (dec.word),
        .way0_rd_i     (way0_rd),
        .way1_rd_i     (way1_rd),
        .refill_line_i (refill_line),
        .unc_rdata_i   (unc_rdata_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rdata_o   (rsp_rdata_o),
        .rsp_miss_o    (rsp_miss_o)
    );

endmodule

/* source/req_decode.sv */
`timescale 1ns/1ps

module req_decode (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req_valid_i,
    input  dcache_pkg::cache_req_t          req_i,
    output logic                            dec_valid_o,
    output dcache_pkg::decoded_req_t        dec_o,
    output logic [dcache_pkg::INDEX_W-1:0]  rd_index_o
);

    dcache_pkg::decoded_req_t dec_d;

    // addr = tag | index | word | byte
    always_comb begin
        dec_d.op       = req_i.op;
        dec_d.tag      = req_i.addr[31 -: dcache_pkg::TAG_W];
        dec_d.index    = req_i.addr[dcache_pkg::WORD_W+2 +: dcache_pkg::INDEX_W];
        dec_d.word     = req_i.addr[2 +: dcache_pkg::WORD_W];
        dec_d.wdata    = req_i.wdata;
        dec_d.wstrb    = req_i.wstrb;
        dec_d.uncached = req_i.uncached;
        dec_d.addr     = req_i.addr;
        for (int b = 0; b < 4; b++) begin
            dec_d.bmask[8*b +: 8] = {8{req_i.wstrb[b]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= req_valid_i;
        end
    end

    // held for the whole transaction
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            dec_o <= dec_d;
        end
    end

    // arrays see the new index in the strobe cycle, data is ready at lookup
    assign rd_index_o = req_valid_i ? dec_d.index : dec_o.index;

endmodule

/* source/resp_mux.sv */
`timescale 1ns/1ps

module resp_mux (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rsp_fire_i,
    input  dcache_pkg::rsp_sel_e            rsp_sel_i,
    input  logic                            rsp_miss_i,
    input  logic [dcache_pkg::WORD_W-1:0]   word_i,
    input  dcache_pkg::way_rd_t             way0_rd_i,
    input  dcache_pkg::way_rd_t             way1_rd_i,
    input  dcache_pkg::line_t               refill_line_i,
    input  logic [31:0]                     unc_rdata_i,
    output logic                            rsp_valid_o,
    output logic [31:0]                     rsp_rdata_o,
    output logic                            rsp_miss_o
);

    logic        hit_fire;
    logic [31:0] hit_word, mem_word, mem_word_q;
    logic        mem_valid_q, miss_q;

    // way outputs are already registered, hits go straight out
    assign hit_fire = rsp_fire_i &&
                      (rsp_sel_i == dcache_pkg::SEL_WAY0 || rsp_sel_i == dcache_pkg::SEL_WAY1);
    assign hit_word = (rsp_sel_i == dcache_pkg::SEL_WAY1) ? way1_rd_i.line[word_i*32 +: 32]
                                                          : way0_rd_i.line[word_i*32 +: 32];
    assign mem_word = (rsp_sel_i == dcache_pkg::SEL_UNC) ? unc_rdata_i
                                                         : refill_line_i[word_i*32 +: 32];

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid_q <= 1'b0;
        end else begin
            mem_valid_q <= rsp_fire_i && !hit_fire;   // refill or uncached return
        end
    end

    always_ff @(posedge clk) begin
        mem_word_q <= mem_word;
        miss_q     <= rsp_miss_i;
    end

    assign rsp_valid_o = hit_fire || mem_valid_q;
    assign rsp_rdata_o = hit_fire ? hit_word : mem_word_q;
    assign rsp_miss_o  = mem_valid_q && miss_q;

endmodule

/* source/way_store.sv */
`timescale 1ns/1ps

module way_store (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [dcache_pkg::INDEX_W-1:0]  rd_index_i,
    input  dcache_pkg::way_wr_t             wr_i,
    output dcache_pkg::way_rd_t             rd_o
);

    logic [dcache_pkg::TAG_W-1:0]    tag_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] valid_q;
    logic [31:0] bank_mem [dcache_pkg::LINE_WORDS][dcache_pkg::NUM_SETS];

    logic                         rd_valid_q;
    logic [dcache_pkg::TAG_W-1:0] rd_tag_q;
    dcache_pkg::line_t            rd_line_q;

    // cold cache misses everywhere
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr_i.tag_we) begin
            valid_q[wr_i.index] <= wr_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.tag_we) begin
            tag_mem[wr_i.index] <= wr_i.tag;
        end
        for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
            if (wr_i.word_we[w]) begin
                bank_mem[w][wr_i.index] <= wr_i.data[32*w +: 32];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_index_i];
        end
    end

    // synchronous read, one cycle after the index
    always_ff @(posedge clk) begin
        rd_tag_q <= tag_mem[rd_index_i];
        for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
            rd_line_q[32*w +: 32] <= bank_mem[w][rd_index_i];
        end
    end

    assign rd_o = '{valid: rd_valid_q, tag: rd_tag_q, line: rd_line_q};

endmodule

/* test/dcache_props.sv */
`timescale 1ns/1ps

module dcache_props (
    input logic clk,
    input logic reset,
    input logic req_valid_i,
    input logic req_uncached_i,
    input logic busy_i,
    input logic rsp_valid_i,
    input logic mem_rd_req_i,
    input logic mem_wr_req_i
);

    int unsigned fail_count = 0;   // failed assertions so far

    // core may only strobe while the cache is idle
    no_req_while_busy: assert property (@(posedge clk) disable iff (reset)
        !(req_valid_i && busy_i))
        else begin
            $error("request strobe while busy");
            fail_count++;
        end

    rsp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rsp_valid_i |=> !rsp_valid_i)
        else begin
            $error("response strobe longer than one cycle");
            fail_count++;
        end

    rd_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req_i |=> !mem_rd_req_i)
        else begin
            $error("line read strobe longer than one cycle");
            fail_count++;
        end

    wr_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req_i |=> !mem_wr_req_i)
        else begin
            $error("line write strobe longer than one cycle");
            fail_count++;
        end

    // lookup cycle either answers a hit or starts line traffic
    hit_next_cycle: assert property (@(posedge clk) disable iff (reset)
        req_valid_i && !req_uncached_i |=> rsp_valid_i || mem_rd_req_i || mem_wr_req_i)
        else begin
            $error("lookup neither answered nor went to memory");
            fail_count++;
        end

endmodule

bind dcache_top dcache_props props0 (
    .clk            (clk),
    .reset          (reset),
    .req_valid_i    (req_valid_i),
    .req_uncached_i (req_i.uncached),
    .busy_i         (busy_o),
    .rsp_valid_i    (rsp_valid_o),
    .mem_rd_req_i   (mem_rd_req_o),
    .mem_wr_req_i   (mem_wr_req_o)
);

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    logic                   clk;
    logic                   reset;
    logic                   req_valid_i;
    dcache_pkg::cache_req_t req_i;
    logic                   mem_ret_valid_i;
    dcache_pkg::line_t      mem_ret_data_i;
    logic                   mem_wr_done_i;
    logic                   unc_done_i;
    logic [31:0]            unc_rdata_i;
    logic                   busy_o;
    logic                   rsp_valid_o;
    logic [31:0]            rsp_rdata_o;
    logic                   rsp_miss_o;
    logic                   mem_rd_req_o;
    logic [31:0]            mem_rd_addr_o;
    logic                   mem_wr_req_o;
    logic [31:0]            mem_wr_addr_o;
    dcache_pkg::line_t      mem_wr_data_o;
    logic                   unc_req_valid_o;
    dcache_pkg::unc_req_t   unc_req_o;

    int seed = 55012;
    int timeout_cycles = 40;
    int errors;
    int tests_failed;
    bit timed_out;
    int edge_cnt, rsp_cnt, rsp_edge, rd_cnt, wr_cnt, unc_cnt, wr_cnt_at_rd;
    logic [31:0]          rsp_data, rd_addr, wr_addr;
    logic                 rsp_miss;
    dcache_pkg::line_t    wr_data;
    dcache_pkg::unc_req_t unc_seen;

    dcache_pkg::line_t mem_lines [logic [26:0]];   // backing memory by line address
    logic [31:0]       shadow [logic [29:0]];      // last value written per word
    logic [dcache_pkg::TAG_W-1:0] m_tag [dcache_pkg::NUM_SETS][2];
    bit m_valid [dcache_pkg::NUM_SETS][2];
    bit m_dirty [dcache_pkg::NUM_SETS][2];
    bit m_lru [dcache_pkg::NUM_SETS];              // way to evict next
    dcache_pkg::cache_req_t steps [$];

    dcache_top dut0 (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h9e37_79b9 ^ {addr[15:2], addr[31:14]};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return shadow.exists(addr[31:2]) ? shadow[addr[31:2]] : fill_word(addr);
    endfunction

    function automatic dcache_pkg::line_t line_at(input logic [26:0] laddr);
        dcache_pkg::line_t l;
        if (mem_lines.exists(laddr)) return mem_lines[laddr];
        for (int w = 0; w < 8; w++) l[32*w +: 32] = fill_word({laddr, w[2:0], 2'b00});
        return l;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int unsigned mem_delay();
        return 2 + ($unsigned($random(seed)) % 5);
    endfunction

    function automatic void add_step(input dcache_pkg::mem_op_e op, input logic [31:0] addr,
                                     input logic [31:0] wd, input logic [3:0] strb,
                                     input logic unc);
        dcache_pkg::cache_req_t s;
        s.op = op;
        s.addr = addr;
        s.wdata = wd;
        s.wstrb = strb;
        s.uncached = unc;
        steps.push_back(s);
    endfunction

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // response monitor, sampled at the rising edge
    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (!reset && rsp_valid_o) begin
            rsp_cnt = rsp_cnt + 1;
            rsp_edge = edge_cnt;
            rsp_data = rsp_rdata_o;
            rsp_miss = rsp_miss_o;
        end
    end

    always begin : line_read_port
        int unsigned dly;
        @(posedge clk);
        if (!reset && mem_rd_req_o) begin
            rd_cnt = rd_cnt + 1;
            rd_addr = mem_rd_addr_o;
            wr_cnt_at_rd = wr_cnt;
            dly = mem_delay();
            repeat (dly) @(negedge clk);
            mem_ret_data_i = line_at(rd_addr[31:5]);
            mem_ret_valid_i = 1'b1;
            @(negedge clk);
            mem_ret_valid_i = 1'b0;
        end
    end

    always begin : line_write_port
        int unsigned dly;
        @(posedge clk);
        if (!reset && mem_wr_req_o) begin
            wr_cnt = wr_cnt + 1;
            wr_addr = mem_wr_addr_o;
            wr_data = mem_wr_data_o;
            mem_lines[wr_addr[31:5]] = wr_data;
            dly = mem_delay();
            repeat (dly) @(negedge clk);
            mem_wr_done_i = 1'b1;
            @(negedge clk);
            mem_wr_done_i = 1'b0;
        end
    end

    always begin : word_port
        int unsigned dly;
        dcache_pkg::line_t l;
        @(posedge clk);
        if (!reset && unc_req_valid_o) begin
            unc_cnt = unc_cnt + 1;
            unc_seen = unc_req_o;
            dly = mem_delay();
            repeat (dly) @(negedge clk);
            l = line_at(unc_seen.addr[31:5]);
            if (unc_seen.op == dcache_pkg::OP_WRITE) begin
                l[32*unc_seen.addr[4:2] +: 32] = merge_bytes(l[32*unc_seen.addr[4:2] +: 32],
                                                             unc_seen.wdata, unc_seen.wstrb);
                mem_lines[unc_seen.addr[31:5]] = l;
            end else begin
                unc_rdata_i = l[32*unc_seen.addr[4:2] +: 32];
            end
            unc_done_i = 1'b1;
            @(negedge clk);
            unc_done_i = 1'b0;
        end
    end

    task automatic run_step(input int idx, input dcache_pkg::cache_req_t r);
        logic [6:0]        index;
        logic [19:0]       tag;
        int                hit_way, waited, r0, w0, u0, p0, req_edge, errs_before;
        bit                victim, exp_miss, exp_wb, is_store;
        logic [31:0]       exp_rdata, wb_addr;
        dcache_pkg::line_t wb_line;
        index = r.addr[11:5];
        tag = r.addr[31:12];
        is_store = (r.op == dcache_pkg::OP_WRITE);
        errs_before = errors;
        exp_rdata = word_at(r.addr);
        hit_way = -1;
        exp_wb = 0;
        victim = m_lru[index];
        if (!r.uncached) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[index][w] && m_tag[index][w] == tag) hit_way = w;
            end
            if (hit_way < 0) begin
                exp_wb = m_valid[index][victim] && m_dirty[index][victim];
                wb_addr = {m_tag[index][victim], index, 5'b0};
                for (int w = 0; w < 8; w++) wb_line[32*w +: 32] = word_at(wb_addr | (w << 2));
            end
        end
        exp_miss = !r.uncached && hit_way < 0;
        waited = 0;
        while (busy_o && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (busy_o) begin
            $display("test %0d: cache stayed busy before the request", idx);
            errors++;
            timed_out = 1;
            return;
        end
        r0 = rd_cnt;
        w0 = wr_cnt;
        u0 = unc_cnt;
        p0 = rsp_cnt;
        req_i = r;
        req_valid_i = 1'b1;
        req_edge = edge_cnt + 1;    // edge that takes the strobe
        @(negedge clk);
        req_valid_i = 1'b0;
        check("busy_o after request", busy_o, 1);
        waited = 0;
        while (rsp_cnt == p0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (rsp_cnt == p0) begin
            $display("test %0d: no response from the cache in time", idx);
            errors++;
            timed_out = 1;
            return;
        end
        check("busy_o after response", busy_o, 0);
        check("rsp_miss_o", rsp_miss, exp_miss);
        if (!is_store) check("rsp_rdata_o", rsp_data, exp_rdata);
        if (hit_way >= 0) check("hit latency", rsp_edge - req_edge, 1);
        check("mem_rd_req_o count", rd_cnt - r0, exp_miss);
        if (exp_miss) check("mem_rd_addr_o", rd_addr, {r.addr[31:5], 5'b0});
        check("mem_wr_req_o count", wr_cnt - w0, exp_wb);
        if (exp_wb) begin
            check("mem_wr_addr_o", wr_addr, wb_addr);
            check("mem_wr_data_o", wr_data, wb_line);
            check("writes before refill", wr_cnt_at_rd - w0, 1);
        end
        check("unc_req_valid_o count", unc_cnt - u0, r.uncached);
        if (r.uncached) check("unc_req_o", unc_seen, {r.op, r.addr, r.wdata, r.wstrb});
        // update the reference model
        if (hit_way >= 0) begin
            m_lru[index] = (hit_way == 0);
            if (is_store) m_dirty[index][hit_way] = 1;
        end else if (exp_miss) begin
            m_tag[index][victim] = tag;
            m_valid[index][victim] = 1;
            m_dirty[index][victim] = is_store;
            m_lru[index] = !victim;
        end
        if (is_store) shadow[r.addr[31:2]] = merge_bytes(exp_rdata, r.wdata, r.wstrb);
        if (errors != errs_before) tests_failed++;
        $display("test %0d %s %s addr %h: %s", idx, r.uncached ? "uncached" : "cached",
                 is_store ? "store" : "load", r.addr, errors == errs_before ? "ok" : "failed");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        mem_ret_valid_i = 1'b0;
        mem_ret_data_i = '0;
        mem_wr_done_i = 1'b0;
        unc_done_i = 1'b0;
        unc_rdata_i = '0;
        add_step(dcache_pkg::OP_READ,  32'h0000_1040, 32'h0,         4'b0000, 1'b0); // cold miss
        add_step(dcache_pkg::OP_READ,  32'h0000_1044, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_WRITE, 32'h0000_1048, 32'hdead_beef, 4'b0101, 1'b0);
        add_step(dcache_pkg::OP_READ,  32'h0000_1048, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_WRITE, 32'h0000_2064, 32'h1234_5678, 4'b1100, 1'b0); // store miss
        add_step(dcache_pkg::OP_READ,  32'h0000_2064, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_WRITE, 32'h0001_00a4, 32'h0bad_f00d, 4'b1111, 1'b0); // set 5
        add_step(dcache_pkg::OP_READ,  32'h0001_10a0, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_READ,  32'h0001_00a0, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_READ,  32'h0001_20a8, 32'h0,         4'b0000, 1'b0); // clean evict
        add_step(dcache_pkg::OP_READ,  32'h0001_00a4, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_READ,  32'h0001_10a0, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_READ,  32'h0001_30ac, 32'h0,         4'b0000, 1'b0); // dirty evict
        add_step(dcache_pkg::OP_READ,  32'h0001_00a4, 32'h0,         4'b0000, 1'b0);
        add_step(dcache_pkg::OP_WRITE, 32'h0000_4010, 32'hcafe_f00d, 4'b0011, 1'b1);
        add_step(dcache_pkg::OP_READ,  32'h0000_4010, 32'h0,         4'b0000, 1'b1);
        add_step(dcache_pkg::OP_READ,  32'h0000_4010, 32'h0,         4'b0000, 1'b0); // no allocate
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("busy_o", busy_o, 0);
        check("rsp_valid_o", rsp_valid_o, 0);
        check("mem_rd_req_o", mem_rd_req_o, 0);
        check("mem_wr_req_o", mem_wr_req_o, 0);
        check("unc_req_valid_o", unc_req_valid_o, 0);
        if (errors != 0) tests_failed++;
        $display("test reset idle: %s", errors == 0 ? "ok" : "failed");
        foreach (steps[i]) begin
            if (!timed_out) run_step(i, steps[i]);
        end
        if (dut0.props0.fail_count != 0) begin
            $display("bound assertions failed %0d times", dut0.props0.fail_count);
            errors++;
        end
        $display("done: %0d tests, %0d failed, %0d errors", steps.size() + 1,
                 tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
